// ==== source/dscrptrSrc_params.svh ====
////////////////////////////////////////////////////////////////////////////
// Sizing macros for the descriptor source arbiter: store depth and the
// widths of descriptor numbers, descriptor words and external addresses
////////////////////////////////////////////////////////////////////////////

`ifndef DSCRPTR_SRC_PARAMS_SVH
`define DSCRPTR_SRC_PARAMS_SVH

// Number of internal buffer descriptors
`define NUM_INT_BDS         4

// Width of an internal descriptor number
`define BD_NUM_WIDTH        2

// One descriptor word
`define DSCRPTR_DATA_WIDTH  133

// External descriptors live in system memory
`define EXT_ADDR_WIDTH      32

`endif

// ==== source/dscrptrSrcPkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Descriptor source types: number, address and data words, source select
// and check machine encodings, invalid descriptor status record
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "dscrptrSrc_params.svh"

package dscrptrSrcPkg;

    typedef logic [`BD_NUM_WIDTH-1:0]       bdNum_t;
    typedef logic [`EXT_ADDR_WIDTH-1:0]     extAddr_t;
    typedef logic [`DSCRPTR_DATA_WIDTH-1:0] dscrptrData_t;

    // Which requester currently owns the descriptor path
    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_NEW_INT,
        SRC_NEXT_INT,
        SRC_LD_EXT
    } srcSel_t;

    // One-hot check machine states
    typedef enum logic [4:0] {
        IDLE            = 5'b00001,
        WAIT_READ_VALID = 5'b00010,
        EXT_READ        = 5'b00100,
        INVALID         = 5'b01000,
        GRANT_RELEASE   = 5'b10000
    } checkState_t;

    // Held for the interrupt logic after an invalid descriptor
    typedef struct packed {
        bdNum_t   dscrptrNum;
        logic     externDscrptr;
        extAddr_t extAddr;
    } dscrptrStatus_t;

endpackage

`default_nettype wire

// ==== source/dscrptrIf.sv ====
////////////////////////////////////////////////////////////////////////////
// Selected descriptor bus between the source mux and the check machine
////////////////////////////////////////////////////////////////////////////

`default_nettype none

interface dscrptrIf;

    import dscrptrSrcPkg::*;

    srcSel_t      srcSel;
    logic         dscrptrValid;
    logic         externDscrptr;
    bdNum_t       intDscrptrNum;
    extAddr_t     extDscrptrAddr;
    dscrptrData_t dscrptrData;

    // Mux side drives every field
    modport source (
        output srcSel,
        output dscrptrValid,
        output externDscrptr,
        output intDscrptrNum,
        output extDscrptrAddr,
        output dscrptrData
    );

    // Check machine never looks at the data word
    modport check (
        input srcSel,
        input dscrptrValid,
        input externDscrptr,
        input intDscrptrNum,
        input extDscrptrAddr
    );

endinterface

`default_nettype wire

// ==== source/dscrptrRoundRobinArbiter.sv ====
////////////////////////////////////////////////////////////////////////////
// Round-robin arbiter with a registered one-hot grant held until acked
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module dscrptrRoundRobinArbiter #(
    parameter int NUM_REQS = 3
) (
    input  wire logic                clock,
    input  wire logic                resetn,
    input  wire logic [NUM_REQS-1:0] req,
    input  wire logic                grantAck,
    output logic      [NUM_REQS-1:0] grant
);

    localparam int PTR_WIDTH = (NUM_REQS > 1) ? $clog2(NUM_REQS) : 1;

    logic [PTR_WIDTH-1:0] ptr;
    logic [PTR_WIDTH-1:0] grantIdx;
    logic [PTR_WIDTH-1:0] nextPtr;
    logic [NUM_REQS-1:0]  winner;
    logic                 found;
    int                   idx;

    //////////////////////////////////////////////////////////////////////////
    // Search from the pointer, wrapping round once
    //////////////////////////////////////////////////////////////////////////
    always_comb
    begin
        winner = '0;
        found  = 1'b0;
        idx    = 0;
        for (int i = 0; i < NUM_REQS; i++)
        begin
            idx = int'(ptr) + i;
            if (idx >= NUM_REQS)
                idx = idx - NUM_REQS;
            if (!found && req[idx])
            begin
                winner[idx] = 1'b1;
                found       = 1'b1;
            end
        end
    end

    // Index of the held grant, then the slot just past it
    always_comb
    begin
        grantIdx = '0;
        for (int j = 0; j < NUM_REQS; j++)
        begin
            if (grant[j])
                grantIdx = PTR_WIDTH'(j);
        end
    end

    assign nextPtr = (grantIdx == PTR_WIDTH'(NUM_REQS - 1)) ? '0 : grantIdx + 1'b1;

    //////////////////////////////////////////////////////////////////////////
    // Grant and pointer registers
    //////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            grant <= '0;
            ptr   <= '0;
        end
        else if (|grant)
        begin
            // New requests wait while a grant is out
            if (grantAck)
            begin
                grant <= '0;
                ptr   <= nextPtr;
            end
        end
        else
        begin
            grant <= winner;
        end
    end

endmodule

`default_nettype wire

// ==== source/dscrptrSourceMux.sv ====
////////////////////////////////////////////////////////////////////////////
// Grant decode, descriptor store address select and descriptor field mux
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module dscrptrSourceMux (
    input  wire logic [2:0]                 grant,
    input  wire dscrptrSrcPkg::bdNum_t      intDscrptrNumStart,
    input  wire dscrptrSrcPkg::bdNum_t      intDscrptrNumTran,
    input  wire logic                       dscrptrValidStore,
    input  wire dscrptrSrcPkg::dscrptrData_t dscrptrDataStore,
    input  wire logic                       extDscrptrValid,
    input  wire dscrptrSrcPkg::bdNum_t      extDscrptrNum,
    input  wire dscrptrSrcPkg::extAddr_t    extDscrptrAddrIn,
    input  wire dscrptrSrcPkg::dscrptrData_t extDscrptrData,
    output dscrptrSrcPkg::bdNum_t           intDscrptrStoreNum,
    dscrptrIf.source                        bus
);

    import dscrptrSrcPkg::*;

    srcSel_t srcSel;

    // One-hot grant to source select, bit order matches the request vector
    always_comb
    begin
        case (grant)
            3'b001:  srcSel = SRC_NEW_INT;
            3'b010:  srcSel = SRC_NEXT_INT;
            3'b100:  srcSel = SRC_LD_EXT;
            default: srcSel = SRC_NONE;
        endcase
    end

    // Chain fetches address the store with the transfer controller's number
    assign intDscrptrStoreNum = (srcSel == SRC_NEXT_INT) ? intDscrptrNumTran
                                                         : intDscrptrNumStart;

    assign bus.srcSel = srcSel;

    always_comb
    begin
        case (srcSel)
            SRC_NEW_INT, SRC_NEXT_INT:
            begin
                bus.dscrptrValid   = dscrptrValidStore;
                bus.externDscrptr  = 1'b0;
                bus.intDscrptrNum  = intDscrptrStoreNum;
                bus.extDscrptrAddr = '0;
                bus.dscrptrData    = dscrptrDataStore;
            end
            SRC_LD_EXT:
            begin
                bus.dscrptrValid   = extDscrptrValid;
                bus.externDscrptr  = 1'b1;
                bus.intDscrptrNum  = extDscrptrNum;
                bus.extDscrptrAddr = extDscrptrAddrIn;
                bus.dscrptrData    = extDscrptrData;
            end
            default:
            begin
                bus.dscrptrValid   = 1'b0;
                bus.externDscrptr  = 1'b0;
                bus.intDscrptrNum  = '0;
                bus.extDscrptrAddr = '0;
                bus.dscrptrData    = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/dscrptrValidCheck.sv ====
////////////////////////////////////////////////////////////////////////////
// Descriptor check FSM: store read, load or invalid report, grant release,
// plus the invalid descriptor status registers
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module dscrptrValidCheck (
    input  wire logic                   clock,
    input  wire logic                   resetn,
    dscrptrIf.check                     bus,
    input  wire logic                   readDscrptrValid,
    input  wire logic                   dscrptrNValidAck,
    output logic                        readDscrptr,
    output logic                        ldDscrptr,
    output logic                        ldIntDscrptrAck,
    output logic                        intFetchAck,
    output logic                        ldExtDscrptrAck,
    output logic                        grantAck,
    output logic                        dscrptrNValid,
    output dscrptrSrcPkg::dscrptrStatus_t status
);

    import dscrptrSrcPkg::*;

    checkState_t    state;
    checkState_t    nextState;
    logic           checkDone;
    logic           dscrptrNValidNext;
    dscrptrStatus_t statusNext;

    //////////////////////////////////////////////////////////////////////////
    // Next state and pulse outputs
    //////////////////////////////////////////////////////////////////////////
    always_comb
    begin
        nextState         = state;
        readDscrptr       = 1'b0;
        grantAck          = 1'b0;
        checkDone         = 1'b0;
        dscrptrNValidNext = 1'b0;

        case (state)
            IDLE:
            begin
                if (bus.srcSel == SRC_LD_EXT)
                begin
                    // External fields are already stable, check next cycle
                    nextState = EXT_READ;
                end
                else if (bus.srcSel != SRC_NONE)
                begin
                    readDscrptr = 1'b1;
                    if (readDscrptrValid)
                        checkDone = 1'b1;
                    else
                        nextState = WAIT_READ_VALID;
                end
            end
            WAIT_READ_VALID:
            begin
                // Keep the read up through the valid cycle
                readDscrptr = 1'b1;
                if (readDscrptrValid)
                    checkDone = 1'b1;
            end
            EXT_READ:
            begin
                checkDone = 1'b1;
            end
            INVALID:
            begin
                if (dscrptrNValidAck)
                begin
                    grantAck  = 1'b1;
                    nextState = IDLE;
                end
                else
                begin
                    dscrptrNValidNext = 1'b1;
                end
            end
            GRANT_RELEASE:
            begin
                grantAck  = 1'b1;
                nextState = IDLE;
            end
            default:
            begin
                nextState = IDLE;
            end
        endcase

        // Descriptor is on the bus, decide load or report
        if (checkDone)
        begin
            if (bus.dscrptrValid)
                nextState = GRANT_RELEASE;
            else
            begin
                dscrptrNValidNext = 1'b1;
                nextState         = INVALID;
            end
        end
    end

    // Acknowledge goes back to whichever requester owns the grant
    assign ldIntDscrptrAck = checkDone && (bus.srcSel == SRC_NEW_INT);
    assign intFetchAck     = checkDone && (bus.srcSel == SRC_NEXT_INT);
    assign ldExtDscrptrAck = checkDone && (bus.srcSel == SRC_LD_EXT);
    assign ldDscrptr       = checkDone && bus.dscrptrValid;

    // Snapshot the bus before the grant goes away
    always_comb
    begin
        statusNext = status;
        if (checkDone && !bus.dscrptrValid)
        begin
            statusNext.dscrptrNum    = bus.intDscrptrNum;
            statusNext.externDscrptr = bus.externDscrptr;
            statusNext.extAddr       = bus.extDscrptrAddr;
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // State, invalid flag and status registers
    //////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            state         <= IDLE;
            dscrptrNValid <= 1'b0;
            status        <= '0;
        end
        else
        begin
            state         <= nextState;
            dscrptrNValid <= dscrptrNValidNext;
            status        <= statusNext;
        end
    end

endmodule

`default_nettype wire

// ==== source/dscrptrSrcMux.sv ====
////////////////////////////////////////////////////////////////////////////
// Descriptor source arbiter top: round-robin arbiter, source mux and
// check FSM joined by the descriptor bus
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module dscrptrSrcMux (
    input  wire logic                        clock,
    input  wire logic                        resetn,
    input  wire logic                        ldIntDscrptr,
    input  wire dscrptrSrcPkg::bdNum_t       intDscrptrNumStart,
    input  wire logic                        fetchIntDscrptr,
    input  wire dscrptrSrcPkg::bdNum_t       intDscrptrNumTran,
    input  wire logic                        dscrptrValidStore,
    input  wire dscrptrSrcPkg::dscrptrData_t dscrptrDataStore,
    input  wire logic                        readDscrptrValid,
    input  wire logic                        ldExtDscrptr,
    input  wire logic                        extDscrptrValid,
    input  wire dscrptrSrcPkg::bdNum_t       extDscrptrNum,
    input  wire dscrptrSrcPkg::extAddr_t     extDscrptrAddrIn,
    input  wire dscrptrSrcPkg::dscrptrData_t extDscrptrData,
    input  wire logic                        dscrptrNValidAck,
    output logic                             ldIntDscrptrAck,
    output logic                             intFetchAck,
    output logic                             ldExtDscrptrAck,
    output logic                             readDscrptr,
    output dscrptrSrcPkg::bdNum_t            intDscrptrStoreNum,
    output logic                             ldDscrptr,
    output logic                             externDscrptr,
    output dscrptrSrcPkg::bdNum_t            intDscrptrNum,
    output dscrptrSrcPkg::extAddr_t          extDscrptrAddr,
    output dscrptrSrcPkg::dscrptrData_t      dscrptrData,
    output logic                             dscrptrNValid,
    output dscrptrSrcPkg::bdNum_t            nValidDscrptrNum,
    output logic                             nValidExtern,
    output dscrptrSrcPkg::extAddr_t          nValidExtAddr
);

    import dscrptrSrcPkg::*;

    logic [2:0]     req;
    logic [2:0]     grant;
    logic           grantAck;
    dscrptrStatus_t status;

    dscrptrIf dscrptrBus ();

    // Bit 0 start controller, bit 1 chain fetch, bit 2 external fetch
    assign req = {ldExtDscrptr, fetchIntDscrptr, ldIntDscrptr};

    dscrptrRoundRobinArbiter #(
        .NUM_REQS (3)
    ) arbiter (
        .clock    (clock),
        .resetn   (resetn),
        .req      (req),
        .grantAck (grantAck),
        .grant    (grant)
    );

    dscrptrSourceMux sourceMux (
        .grant              (grant),
        .intDscrptrNumStart (intDscrptrNumStart),
        .intDscrptrNumTran  (intDscrptrNumTran),
        .dscrptrValidStore  (dscrptrValidStore),
        .dscrptrDataStore   (dscrptrDataStore),
        .extDscrptrValid    (extDscrptrValid),
        .extDscrptrNum      (extDscrptrNum),
        .extDscrptrAddrIn   (extDscrptrAddrIn),
        .extDscrptrData     (extDscrptrData),
        .intDscrptrStoreNum (intDscrptrStoreNum),
        .bus                (dscrptrBus.source)
    );

    dscrptrValidCheck validCheck (
        .clock            (clock),
        .resetn           (resetn),
        .bus              (dscrptrBus.check),
        .readDscrptrValid (readDscrptrValid),
        .dscrptrNValidAck (dscrptrNValidAck),
        .readDscrptr      (readDscrptr),
        .ldDscrptr        (ldDscrptr),
        .ldIntDscrptrAck  (ldIntDscrptrAck),
        .intFetchAck      (intFetchAck),
        .ldExtDscrptrAck  (ldExtDscrptrAck),
        .grantAck         (grantAck),
        .dscrptrNValid    (dscrptrNValid),
        .status           (status)
    );

    // Selected descriptor out to the loader
    assign externDscrptr  = dscrptrBus.externDscrptr;
    assign intDscrptrNum  = dscrptrBus.intDscrptrNum;
    assign extDscrptrAddr = dscrptrBus.extDscrptrAddr;
    assign dscrptrData    = dscrptrBus.dscrptrData;

    // Status fields for the interrupt logic
    assign nValidDscrptrNum = status.dscrptrNum;
    assign nValidExtern     = status.externDscrptr;
    assign nValidExtAddr    = status.extAddr;

endmodule

`default_nettype wire

// ==== dv/dscrptrSrcMuxTb.sv ====
////////////////////////////////////////////////////////////////////////////
// Descriptor source arbiter testbench with random requesters, store and
// invalid-ack responders, a round-robin reference model and checks
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "dscrptrSrc_params.svh"

module dscrptrSrcMuxTb;

    import dscrptrSrcPkg::*;

    localparam int NUM_GRANTS     = 400;
    localparam int TIMEOUT_CYCLES = NUM_GRANTS * 20;

    logic         clock;
    logic         resetn;
    logic [2:0]   reqLine;
    bdNum_t       intDscrptrNumStart;
    bdNum_t       intDscrptrNumTran;
    logic         dscrptrValidStore;
    dscrptrData_t dscrptrDataStore;
    logic         readDscrptrValid;
    logic         extDscrptrValid;
    bdNum_t       extDscrptrNum;
    extAddr_t     extDscrptrAddrIn;
    dscrptrData_t extDscrptrData;
    logic         dscrptrNValidAck;

    logic         ldIntDscrptrAck;
    logic         intFetchAck;
    logic         ldExtDscrptrAck;
    logic         readDscrptr;
    bdNum_t       intDscrptrStoreNum;
    logic         ldDscrptr;
    logic         externDscrptr;
    bdNum_t       intDscrptrNum;
    extAddr_t     extDscrptrAddr;
    dscrptrData_t dscrptrData;
    logic         dscrptrNValid;
    bdNum_t       nValidDscrptrNum;
    logic         nValidExtern;
    extAddr_t     nValidExtAddr;
    logic [2:0]   ackLine;

    // Descriptor store contents
    logic         storeValid [`NUM_INT_BDS];
    dscrptrData_t storeData [`NUM_INT_BDS];

    // Reference model state
    int           rrPtr;
    int           expGrant;
    bit           held;
    bit           acked;
    bit           relNext;
    bit           waitNAck;
    bit           nvExp;
    bdNum_t       expStatNum;
    bit           expStatExt;
    extAddr_t     expStatAddr;
    int           grantCount;
    int           cycleCount;

    assign ackLine = {ldExtDscrptrAck, intFetchAck, ldIntDscrptrAck};

    dscrptrSrcMux uut (
        .clock              (clock),
        .resetn             (resetn),
        .ldIntDscrptr       (reqLine[0]),
        .intDscrptrNumStart (intDscrptrNumStart),
        .fetchIntDscrptr    (reqLine[1]),
        .intDscrptrNumTran  (intDscrptrNumTran),
        .dscrptrValidStore  (dscrptrValidStore),
        .dscrptrDataStore   (dscrptrDataStore),
        .readDscrptrValid   (readDscrptrValid),
        .ldExtDscrptr       (reqLine[2]),
        .extDscrptrValid    (extDscrptrValid),
        .extDscrptrNum      (extDscrptrNum),
        .extDscrptrAddrIn   (extDscrptrAddrIn),
        .extDscrptrData     (extDscrptrData),
        .dscrptrNValidAck   (dscrptrNValidAck),
        .ldIntDscrptrAck    (ldIntDscrptrAck),
        .intFetchAck        (intFetchAck),
        .ldExtDscrptrAck    (ldExtDscrptrAck),
        .readDscrptr        (readDscrptr),
        .intDscrptrStoreNum (intDscrptrStoreNum),
        .ldDscrptr          (ldDscrptr),
        .externDscrptr      (externDscrptr),
        .intDscrptrNum      (intDscrptrNum),
        .extDscrptrAddr     (extDscrptrAddr),
        .dscrptrData        (dscrptrData),
        .dscrptrNValid      (dscrptrNValid),
        .nValidDscrptrNum   (nValidDscrptrNum),
        .nValidExtern       (nValidExtern),
        .nValidExtAddr      (nValidExtAddr)
    );

    always #5 clock = ~clock;

    //////////////////////////////////////////////////////////////////////////
    // Check helpers
    //////////////////////////////////////////////////////////////////////////
    task automatic stopOnFailure();
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [`DSCRPTR_DATA_WIDTH-1:0] actual,
                              input logic [`DSCRPTR_DATA_WIDTH-1:0] expected);
        assert (actual === expected)
        else
        begin
            $display("[FAIL] %s: got %h, expected %h", name, actual, expected);
            stopOnFailure();
        end
    endtask

    task automatic expectTrue(input bit cond, input string what);
        assert (cond)
        else
        begin
            $display("Error: %s", what);
            stopOnFailure();
        end
    endtask

    function automatic dscrptrData_t randomWord();
        logic [159:0] wide;
        wide = {$urandom(), $urandom(), $urandom(), $urandom(), $urandom()};
        return wide[`DSCRPTR_DATA_WIDTH-1:0];
    endfunction

    // Everything idle straight after reset
    task automatic checkIdleOutputs();
        checkValue("readDscrptr", readDscrptr, 0);
        checkValue("ldDscrptr", ldDscrptr, 0);
        checkValue("ackLine", ackLine, 0);
        checkValue("dscrptrNValid", dscrptrNValid, 0);
        checkValue("externDscrptr", externDscrptr, 0);
        checkValue("intDscrptrNum", intDscrptrNum, 0);
        checkValue("extDscrptrAddr", extDscrptrAddr, 0);
        checkValue("dscrptrData", dscrptrData, 0);
        checkValue("nValidDscrptrNum", nValidDscrptrNum, 0);
        checkValue("nValidExtern", nValidExtern, 0);
        checkValue("nValidExtAddr", nValidExtAddr, 0);
    endtask

    //////////////////////////////////////////////////////////////////////////
    // Requesters and responders
    //////////////////////////////////////////////////////////////////////////
    task automatic runRequester(input int idx);
        int idle;
        forever
        begin
            idle = 1 + ($urandom() % 6);
            repeat (idle) @(posedge clock);
            #1;
            case (idx)
                0: intDscrptrNumStart = bdNum_t'($urandom());
                1: intDscrptrNumTran = bdNum_t'($urandom());
                default:
                begin
                    extDscrptrNum    = bdNum_t'($urandom());
                    extDscrptrAddrIn = $urandom();
                    extDscrptrData   = randomWord();
                    extDscrptrValid  = ($urandom() % 4) != 0;
                end
            endcase
            reqLine[idx] = 1'b1;
            do
                @(negedge clock);
            while (!ackLine[idx]);
            @(posedge clock);
            #1;
            reqLine[idx] = 1'b0;
        end
    endtask

    // A zero delay answers in the same cycle the read is raised
    task automatic runStore();
        bdNum_t num;
        int     delay;
        forever
        begin
            @(posedge clock);
            #1;
            if (readDscrptr)
            begin
                num   = intDscrptrStoreNum;
                delay = $urandom() % 6;
                repeat (delay)
                begin
                    @(posedge clock);
                    #1;
                end
                readDscrptrValid  = 1'b1;
                dscrptrValidStore = storeValid[num];
                dscrptrDataStore  = storeData[num];
                @(posedge clock);
                #1;
                readDscrptrValid  = 1'b0;
                dscrptrValidStore = 1'b0;
                // Descriptor gets rewritten after each use
                storeValid[num] = ($urandom() % 4) != 0;
                storeData[num]  = randomWord();
            end
        end
    endtask

    task automatic runNValidAck();
        int delay;
        forever
        begin
            @(posedge clock);
            #1;
            if (dscrptrNValid)
            begin
                delay = $urandom() % 6;
                repeat (delay)
                begin
                    @(posedge clock);
                    #1;
                end
                dscrptrNValidAck = 1'b1;
                @(posedge clock);
                #1;
                dscrptrNValidAck = 1'b0;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////////
    // Monitor and reference model sampled mid-cycle
    //////////////////////////////////////////////////////////////////////////
    always @(negedge clock)
    begin : monitor
        int     ackIdx;
        int     cand;
        bit     found;
        bdNum_t expNum;
        logic   expValid;
        if (resetn)
        begin
            ackIdx   = -1;
            expValid = 1'b0;
            expNum   = '0;
            case (ackLine)
                3'b000: ackIdx = -1;
                3'b001: ackIdx = 0;
                3'b010: ackIdx = 1;
                3'b100: ackIdx = 2;
                default: expectTrue(0, "more than one requester acknowledged at once");
            endcase

            if (held && !acked && expGrant != 2)
                expectTrue(readDscrptr, "readDscrptr low while an internal grant waits");
            if (readDscrptr)
            begin
                expectTrue(held && !acked && expGrant != 2,
                           "readDscrptr high without an internal grant");
                expNum = (expGrant == 1) ? intDscrptrNumTran : intDscrptrNumStart;
                checkValue("intDscrptrStoreNum", intDscrptrStoreNum, expNum);
            end

            checkValue("dscrptrNValid", dscrptrNValid, nvExp);
            checkValue("nValidDscrptrNum", nValidDscrptrNum, expStatNum);
            checkValue("nValidExtern", nValidExtern, expStatExt);
            checkValue("nValidExtAddr", nValidExtAddr, expStatAddr);

            if (ackIdx < 0)
                checkValue("ldDscrptr", ldDscrptr, 0);
            else
            begin
                expectTrue(held && !acked, "acknowledge came without an outstanding grant");
                checkValue("ackLine", ackLine, 3'b001 << expGrant);
                if (ackIdx == 2)
                begin
                    expNum   = extDscrptrNum;
                    expValid = extDscrptrValid;
                end
                else
                begin
                    expectTrue(readDscrptrValid, "internal acknowledge before the store answered");
                    expNum   = (ackIdx == 1) ? intDscrptrNumTran : intDscrptrNumStart;
                    expValid = storeValid[expNum];
                end
                checkValue("ldDscrptr", ldDscrptr, expValid);
                if (expValid)
                begin
                    checkValue("externDscrptr", externDscrptr, ackIdx == 2);
                    checkValue("intDscrptrNum", intDscrptrNum, expNum);
                    checkValue("extDscrptrAddr", extDscrptrAddr,
                               (ackIdx == 2) ? extDscrptrAddrIn : extAddr_t'(0));
                    checkValue("dscrptrData", dscrptrData,
                               (ackIdx == 2) ? extDscrptrData : storeData[expNum]);
                end
            end

            // Model update for the coming edge
            if (nvExp && dscrptrNValidAck)
                nvExp = 1'b0;
            if (held)
            begin
                if (relNext || (waitNAck && dscrptrNValidAck))
                begin
                    held     = 1'b0;
                    relNext  = 1'b0;
                    waitNAck = 1'b0;
                    rrPtr    = (expGrant + 1) % 3;
                end
            end
            else if (reqLine != 3'b000)
            begin
                found = 1'b0;
                for (int i = 0; i < 3; i++)
                begin
                    cand = (rrPtr + i) % 3;
                    if (!found && reqLine[cand])
                    begin
                        expGrant = cand;
                        found    = 1'b1;
                    end
                end
                held  = 1'b1;
                acked = 1'b0;
            end

            if (ackIdx >= 0)
            begin
                acked      = 1'b1;
                grantCount = grantCount + 1;
                if (expValid)
                    relNext = 1'b1;
                else
                begin
                    waitNAck    = 1'b1;
                    nvExp       = 1'b1;
                    expStatNum  = expNum;
                    expStatExt  = (ackIdx == 2);
                    expStatAddr = (ackIdx == 2) ? extDscrptrAddrIn : extAddr_t'(0);
                end
            end
        end
    end

    always @(posedge clock)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: %0d of %0d grants done after %0d cycles",
                     grantCount, NUM_GRANTS, cycleCount);
            stopOnFailure();
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////////
    initial
    begin
        void'($urandom(32'hcf4fbd61));
        clock              = 1'b0;
        resetn             = 1'b0;
        reqLine            = '0;
        intDscrptrNumStart = '0;
        intDscrptrNumTran  = '0;
        dscrptrValidStore  = 1'b0;
        dscrptrDataStore   = '0;
        readDscrptrValid   = 1'b0;
        extDscrptrValid    = 1'b0;
        extDscrptrNum      = '0;
        extDscrptrAddrIn   = '0;
        extDscrptrData     = '0;
        dscrptrNValidAck   = 1'b0;
        rrPtr              = 0;
        expGrant           = 0;
        held               = 1'b0;
        acked              = 1'b0;
        relNext            = 1'b0;
        waitNAck           = 1'b0;
        nvExp              = 1'b0;
        expStatNum         = '0;
        expStatExt         = 1'b0;
        expStatAddr        = '0;
        grantCount         = 0;
        cycleCount         = 0;
        for (int i = 0; i < `NUM_INT_BDS; i++)
        begin
            storeValid[i] = ($urandom() % 4) != 0;
            storeData[i]  = randomWord();
        end

        repeat (8) @(posedge clock);
        #1;
        resetn = 1'b1;
        @(negedge clock);
        checkIdleOutputs();

        fork
            runRequester(0);
            runRequester(1);
            runRequester(2);
            runStore();
            runNValidAck();
        join_none

        wait (grantCount >= NUM_GRANTS);
        repeat (10) @(posedge clock);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+source
source/dscrptrSrcPkg.sv
source/dscrptrIf.sv
source/dscrptrRoundRobinArbiter.sv
source/dscrptrSourceMux.sv
source/dscrptrValidCheck.sv
source/dscrptrSrcMux.sv
dv/dscrptrSrcMuxTb.sv
